//--- project.f
src/can_cfg_pkg.sv
src/can_cfg_if.sv
src/can_step_timer.sv
src/can_reg_formatter.sv
src/can_cfg_sequencer.sv
src/can_cfg_top.sv
bench/can_cfg_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module can_cfg_tb \
  -f project.f -Mdir obj_dir -o sim_can_cfg
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_can_cfg > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
exit 0

//--- bench/can_cfg_tb.sv
module can_cfg_tb;
  import can_cfg_pkg::*;

  localparam int MAX_WAIT = 200; // Cycles before a wait gives up

  logic             clk;
  logic             rst;
  logic             init_cmd;
  logic             send_cmd;
  logic             trim_cmd;
  logic             bus_reset_cmd;
  logic [15:0]      prescaler_init;
  logic [15:0]      general_init;
  logic [MSG_W-1:0] data_tra_mes;
  logic [4:0]       reg_addr;
  logic [15:0]      reg_wdata;
  logic             reg_we;
  logic             busy;
  logic             done;

  logic [31:0] lfsr;          // Stimulus generator state
  int          phase;         // Cycles since acceptance or 0 when idle
  int          exp_len;       // Writes in the expected sequence
  int          last_we;       // Phase of the final write
  logic [4:0]  exp_addr [7];
  logic [15:0] exp_word [7];
  logic [2:0]  wr_idx;        // Write number at this phase
  logic        exp_we;
  logic        exp_busy;
  logic        exp_done;
  logic        started;       // Some command accepted since reset

  can_cfg_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
  endfunction

  // One LFSR step per bit
  task automatic draw(input int n, output logic [MSG_W-1:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[MSG_W-2:0], lfsr[0]};
    end
  endtask

  // Register order per command
  function automatic logic [4:0] entry_addr(input cfg_op_t op, input logic [2:0] i);
    logic [4:0] init_list [7];
    logic [4:0] tx_list [7];
    init_list = '{ADDR_PRESCALER, ADDR_GENERAL, ADDR_ID_HI, ADDR_ID_LO,
                  ADDR_MASK_HI, ADDR_MASK_LO, ADDR_IRQ};
    tx_list   = '{ADDR_TRA_ID, ADDR_TRA_D12, ADDR_TRA_D34, ADDR_TRA_D56,
                  ADDR_TRA_D78, ADDR_GENERAL, ADDR_TRA_CTRL};
    if (op == op_init) return init_list[i];
    if (op == op_bus_reset) return (i == 3'd0) ? ADDR_GENERAL : ADDR_IRQ;
    return tx_list[i];
  endfunction

  function automatic logic [15:0] entry_word(input cfg_op_t op, input logic [2:0] i,
                                             input logic [15:0] pre, input logic [15:0] gen,
                                             input logic [MSG_W-1:0] msg);
    logic [MSG_W-1:0] m;
    m = (op == op_trim) ? TRIM_PATTERN : msg; // Trim ignores host message
    if (op == op_init) begin
      if (i == 3'd0) return pre;
      if (i == 3'd1) return gen;
      return (i == 3'd6) ? IRQ_ENABLE_WORD : 16'h0000; // ID and mask cleared
    end
    if (op == op_bus_reset) return (i == 3'd0) ? GEN_DATA_WORD : IRQ_ENABLE_WORD;
    case (i)
      3'd0:    return {m[74:64], 5'b00000};
      3'd1:    return {m[63:56], m[47:40]};
      3'd2:    return {m[55:48], m[39:32]};
      3'd3:    return {m[7:0], m[15:8]};
      3'd4:    return {m[23:16], m[31:24]};
      3'd5:    return GEN_DATA_WORD;
      default: return TRA_CONTROL_WORD;
    endcase
  endfunction

  // Expected outputs from phase
  always_comb begin
    last_we  = 2 + (WRITE_GAP + 2) * (exp_len - 1);
    wr_idx   = (phase >= 2) ? 3'((phase - 2) / (WRITE_GAP + 2)) : 3'd0;
    exp_we   = (phase >= 2) && ((phase - 2) % (WRITE_GAP + 2) == 0) && (phase <= last_we);
    exp_done = (phase != 0) && (phase == last_we + WRITE_GAP + 1);
    exp_busy = (phase != 0);
  end

  // Reference model latching host values on accept
  always @(posedge clk) begin : model
    cfg_op_t op;
    if (!rst) begin
      phase   <= 0;
      exp_len <= 0;
      started <= 1'b0;
    end else if (phase == 0) begin
      if (init_cmd || bus_reset_cmd || send_cmd || trim_cmd) begin
        op = init_cmd ? op_init : bus_reset_cmd ? op_bus_reset : send_cmd ? op_send : op_trim;
        for (int i = 0; i < 7; i++) begin
          exp_addr[i] <= entry_addr(op, 3'(i));
          exp_word[i] <= entry_word(op, 3'(i), prescaler_init, general_init, data_tra_mes);
        end
        case (op)
          op_init: exp_len <= int'(INIT_LEN);
          op_send: exp_len <= int'(SEND_LEN);
          op_trim: exp_len <= int'(TRIM_LEN);
          default: exp_len <= int'(RESET_LEN);
        endcase
        phase   <= 1;
        started <= 1'b1;
      end
    end else if (phase == last_we + WRITE_GAP + 1) begin
      phase <= 0;                                   // Done cycle returns to idle
    end else begin
      phase <= phase + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  a_busy: assert property (@(posedge clk) disable iff (!rst) busy == exp_busy)
    else report_mismatch("busy", 32'($sampled(busy)), 32'($sampled(exp_busy)));
  a_we: assert property (@(posedge clk) disable iff (!rst) reg_we == exp_we)
    else report_mismatch("reg_we", 32'($sampled(reg_we)), 32'($sampled(exp_we)));
  a_done: assert property (@(posedge clk) disable iff (!rst) done == exp_done)
    else report_mismatch("done", 32'($sampled(done)), 32'($sampled(exp_done)));
  a_addr: assert property (@(posedge clk) disable iff (!rst)
    exp_we |-> (reg_addr == exp_addr[wr_idx]))
    else report_mismatch("reg_addr", 32'($sampled(reg_addr)), 32'($sampled(exp_addr[wr_idx])));
  a_wdata: assert property (@(posedge clk) disable iff (!rst)
    exp_we |-> (reg_wdata == exp_word[wr_idx]))
    else report_mismatch("reg_wdata", 32'($sampled(reg_wdata)), 32'($sampled(exp_word[wr_idx])));
  a_addr_rst: assert property (@(posedge clk) disable iff (!rst) !started |-> reg_addr == 5'h00)
    else report_mismatch("reg_addr", 32'($sampled(reg_addr)), 32'h0);
  a_wdata_rst: assert property (@(posedge clk) disable iff (!rst) !started |-> reg_wdata == 16'h0)
    else report_mismatch("reg_wdata", 32'($sampled(reg_wdata)), 32'h0);

  task automatic pulse_cmd(input logic i, input logic s, input logic t, input logic b);
    @(posedge clk);
    init_cmd      <= i;
    send_cmd      <= s;
    trim_cmd      <= t;
    bus_reset_cmd <= b;
    @(posedge clk);               // Accept edge
    init_cmd      <= 1'b0;
    send_cmd      <= 1'b0;
    trim_cmd      <= 1'b0;
    bus_reset_cmd <= 1'b0;
  endtask

  task automatic wait_busy();
    int n;
    n = 0;
    while (!busy) begin
      @(posedge clk);
      n++;
      if (n > MAX_WAIT) report_timeout("busy to rise");
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!done) begin
      @(posedge clk);
      n++;
      if (n > MAX_WAIT) report_timeout("done pulse");
    end
  endtask

  task automatic run_cmd(input logic i, input logic s, input logic t, input logic b);
    pulse_cmd(i, s, t, b);
    wait_busy();
    wait_done();
  endtask

  task automatic new_host_values();
    logic [MSG_W-1:0] r;
    draw(16, r);
    prescaler_init <= r[15:0];
    draw(16, r);
    general_init <= r[15:0];
    draw(MSG_W, r);
    data_tra_mes <= r;
  endtask

  initial begin
    lfsr           = 32'h3c4d;
    rst            = 1'b0;
    init_cmd       = 1'b0;
    send_cmd       = 1'b0;
    trim_cmd       = 1'b0;
    bus_reset_cmd  = 1'b0;
    prescaler_init = 16'h0000;
    general_init   = 16'h0000;
    data_tra_mes   = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);     // Quiet window after reset
    new_host_values();
    run_cmd(1'b1, 1'b0, 1'b0, 1'b0); // Init
    new_host_values();
    pulse_cmd(1'b0, 1'b1, 1'b0, 1'b0); // Send
    new_host_values();              // Changed after accept
    wait_busy();
    wait_done();
    run_cmd(1'b0, 1'b0, 1'b1, 1'b0); // Trim
    run_cmd(1'b0, 1'b0, 1'b0, 1'b1); // Bus reset
    new_host_values();
    pulse_cmd(1'b0, 1'b1, 1'b0, 1'b0);
    wait_busy();
    pulse_cmd(1'b1, 1'b0, 1'b1, 1'b1); // Dropped while busy
    wait_done();
    new_host_values();
    run_cmd(1'b1, 1'b1, 1'b1, 1'b1); // Init wins
    run_cmd(1'b0, 1'b1, 1'b1, 1'b1); // Bus reset wins
    new_host_values();
    run_cmd(1'b0, 1'b1, 1'b1, 1'b0); // Send beats trim
    repeat (4) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- src/can_cfg_top.sv
module can_cfg_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          init_cmd,
  input  logic                          send_cmd,
  input  logic                          trim_cmd,
  input  logic                          bus_reset_cmd,
  input  logic [15:0]                   prescaler_init,
  input  logic [15:0]                   general_init,
  input  logic [can_cfg_pkg::MSG_W-1:0] data_tra_mes,
  output logic [4:0]                    reg_addr,
  output logic [15:0]                   reg_wdata,
  output logic                          reg_we,
  output logic                          busy,
  output logic                          done
);
  import can_cfg_pkg::*;

  cfg_op_t    op_cur;    // Active command to timer
  logic [2:0] step;      // Step index back to sequencer
  logic       clear;
  logic       step_inc;
  logic       gap_start;
  logic       last_step;
  logic       gap_done;

  can_cfg_if bus_if ();

  can_cfg_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .init_cmd      (init_cmd),
    .send_cmd      (send_cmd),
    .trim_cmd      (trim_cmd),
    .bus_reset_cmd (bus_reset_cmd),
    .bus           (bus_if.seq),
    .step          (step),
    .last_step     (last_step),
    .gap_done      (gap_done),
    .clear         (clear),
    .step_inc      (step_inc),
    .gap_start     (gap_start),
    .op_cur        (op_cur),
    .reg_addr      (reg_addr),
    .reg_we        (reg_we),
    .busy          (busy),
    .done          (done)
  );

  can_step_timer u_timer (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .step_inc  (step_inc),
    .gap_start (gap_start),
    .op        (op_cur),
    .step      (step),
    .last_step (last_step),
    .gap_done  (gap_done)
  );

  can_reg_formatter u_fmt (
    .clk            (clk),
    .rst            (rst),
    .bus            (bus_if.fmt),
    .prescaler_init (prescaler_init),
    .general_init   (general_init),
    .data_tra_mes   (data_tra_mes)
  );

  assign reg_wdata = bus_if.word; // Registered in formatter

endmodule

//--- src/can_cfg_sequencer.sv
module can_cfg_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  init_cmd,
  input  logic                  send_cmd,
  input  logic                  trim_cmd,
  input  logic                  bus_reset_cmd,
  can_cfg_if.seq                bus,
  input  logic [2:0]            step,
  input  logic                  last_step,
  input  logic                  gap_done,
  output logic                  clear,
  output logic                  step_inc,
  output logic                  gap_start,
  output can_cfg_pkg::cfg_op_t  op_cur,
  output logic [4:0]            reg_addr,
  output logic                  reg_we,
  output logic                  busy,
  output logic                  done
);
  import can_cfg_pkg::*;

  seq_state_t state, state_nxt;
  cfg_op_t    op_req;  // Winner of strobe arbitration
  logic       accept;  // Command taken this cycle
  logic [4:0] addr_lu; // Address for current step

  // Register walk order per command
  function automatic logic [4:0] addr_table(input cfg_op_t op, input logic [2:0] idx);
    logic [4:0] a;
    a = 5'h00;
    case (op)
      op_init: begin
        case (idx)
          3'd0:    a = ADDR_PRESCALER;
          3'd1:    a = ADDR_GENERAL;
          3'd2:    a = ADDR_ID_HI;
          3'd3:    a = ADDR_ID_LO;
          3'd4:    a = ADDR_MASK_HI;
          3'd5:    a = ADDR_MASK_LO;
          3'd6:    a = ADDR_IRQ;      // Enable comms last
          default: a = 5'h00;
        endcase
      end
      op_send, op_trim: begin
        case (idx)
          3'd0:    a = ADDR_TRA_ID;
          3'd1:    a = ADDR_TRA_D12;
          3'd2:    a = ADDR_TRA_D34;
          3'd3:    a = ADDR_TRA_D56;
          3'd4:    a = ADDR_TRA_D78;
          3'd5:    a = ADDR_GENERAL;
          3'd6:    a = ADDR_TRA_CTRL; // Kicks off the frame
          default: a = 5'h00;
        endcase
      end
      op_bus_reset: begin
        case (idx)
          3'd0:    a = ADDR_GENERAL;
          3'd1:    a = ADDR_IRQ;
          default: a = 5'h00;
        endcase
      end
      default: a = 5'h00;
    endcase
    return a;
  endfunction

  // Init wins over bus reset, then send, then trim
  always_comb begin
    if (init_cmd)           op_req = op_init;
    else if (bus_reset_cmd) op_req = op_bus_reset;
    else if (send_cmd)      op_req = op_send;
    else if (trim_cmd)      op_req = op_trim;
    else                    op_req = op_idle;
  end

  assign accept  = (state == st_idle) && (op_req != op_idle); // Busy strobes dropped
  assign addr_lu = addr_table(op_cur, step);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:  if (accept) state_nxt = st_fetch;
      st_fetch: state_nxt = st_write;
      st_write: state_nxt = st_gap;
      st_gap:   if (gap_done) state_nxt = last_step ? st_done : st_fetch;
      st_done:  state_nxt = st_idle;
      default:  state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= st_idle;
      op_cur   <= op_idle;
      reg_addr <= 5'h00;
    end else begin
      state <= state_nxt;
      if (accept)
        op_cur <= op_req;                 // Hold command for whole sequence
      else if (state == st_done)
        op_cur <= op_idle;
      if (state == st_fetch)
        reg_addr <= addr_lu;              // Aligned with formatter word
    end
  end

  // Formatter request
  assign bus.op      = op_cur;
  assign bus.addr    = addr_lu;
  assign bus.fetch   = (state == st_fetch);
  assign bus.capture = accept;

  // Timer control
  assign clear     = accept;
  assign step_inc  = (state == st_write);
  assign gap_start = (state == st_write);

  // Controller and host outputs
  assign reg_we = (state == st_write);
  assign busy   = (state != st_idle);
  assign done   = (state == st_done);

  // Strobes are separated by at least the gap
  a_we_single: assert property (@(posedge clk) disable iff (!rst)
    reg_we |=> !reg_we);

  // Command held for the whole busy window
  a_op_busy: assert property (@(posedge clk) disable iff (!rst)
    busy |-> (op_cur != op_idle));

endmodule

//--- src/can_reg_formatter.sv
module can_reg_formatter (
  input  logic                          clk,
  input  logic                          rst,
  can_cfg_if.fmt                        bus,
  input  logic [15:0]                   prescaler_init,
  input  logic [15:0]                   general_init,
  input  logic [can_cfg_pkg::MSG_W-1:0] data_tra_mes
);
  import can_cfg_pkg::*;

  logic [15:0]      prescaler_q; // Host values frozen at accept
  logic [15:0]      general_q;
  logic [MSG_W-1:0] msg_q;
  logic [MSG_W-1:0] msg_src;     // Payload for send or trim
  logic [15:0]      word_nxt;

  always_ff @(posedge clk) begin
    if (bus.capture) begin
      prescaler_q <= prescaler_init;
      general_q   <= general_init;
      msg_q       <= data_tra_mes;
    end
  end

  assign msg_src = (bus.op == op_trim) ? TRIM_PATTERN : msg_q;

  always_comb begin
    word_nxt = 16'h0000;
    case (bus.op)
      op_init: begin
        case (bus.addr)
          ADDR_PRESCALER: word_nxt = prescaler_q;
          ADDR_GENERAL:   word_nxt = general_q;   // SJW and segment split
          ADDR_ID_HI,
          ADDR_ID_LO:     word_nxt = 16'h0000;    // No own ID
          ADDR_MASK_HI,
          ADDR_MASK_LO:   word_nxt = 16'h0000;    // Accept all frames
          ADDR_IRQ:       word_nxt = IRQ_ENABLE_WORD;
          default:        word_nxt = 16'h0000;
        endcase
      end
      op_send, op_trim: begin
        case (bus.addr)
          ADDR_TRA_ID:   word_nxt = {msg_src[74:64], 5'h00};            // 11-bit ID left aligned
          ADDR_TRA_D12:  word_nxt = {msg_src[63:56], msg_src[47:40]};
          ADDR_TRA_D34:  word_nxt = {msg_src[55:48], msg_src[39:32]};
          ADDR_TRA_D56:  word_nxt = {msg_src[7:0],   msg_src[15:8]};    // Low bytes swapped
          ADDR_TRA_D78:  word_nxt = {msg_src[23:16], msg_src[31:24]};
          ADDR_GENERAL:  word_nxt = GEN_DATA_WORD;
          ADDR_TRA_CTRL: word_nxt = TRA_CONTROL_WORD;
          default:       word_nxt = 16'h0000;
        endcase
      end
      op_bus_reset: begin
        case (bus.addr)
          ADDR_GENERAL: word_nxt = GEN_DATA_WORD;
          ADDR_IRQ:     word_nxt = IRQ_ENABLE_WORD; // Re-enable comms
          default:      word_nxt = 16'h0000;
        endcase
      end
      default: word_nxt = 16'h0000;
    endcase
  end

  // Word valid one cycle after fetch and held until next fetch
  always_ff @(posedge clk) begin
    if (!rst)           bus.word <= 16'h0000;
    else if (bus.fetch) bus.word <= word_nxt;
  end

  // Sequencer only fetches inside an active command
  a_fetch_op: assert property (@(posedge clk) disable iff (!rst)
    bus.fetch |-> (bus.op != op_idle));

endmodule

//--- src/can_step_timer.sv
module can_step_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear,
  input  logic                 step_inc,
  input  logic                 gap_start,
  input  can_cfg_pkg::cfg_op_t op,
  output logic [2:0]           step,
  output logic                 last_step,
  output logic                 gap_done
);
  import can_cfg_pkg::*;

  logic [2:0] seq_len; // Writes in active sequence
  logic [2:0] gap_cnt; // Remaining gap cycles
  logic       gap_run; // Gap in progress

  always_comb begin
    case (op)
      op_init:      seq_len = INIT_LEN;
      op_send:      seq_len = SEND_LEN;
      op_trim:      seq_len = TRIM_LEN;
      op_bus_reset: seq_len = RESET_LEN;
      default:      seq_len = 3'd0;
    endcase
  end

  // Writes completed so far
  always_ff @(posedge clk) begin
    if (!rst)          step <= 3'd0;
    else if (clear)    step <= 3'd0;
    else if (step_inc) step <= step + 3'd1;
  end

  assign last_step = (step == seq_len); // All writes issued

  // Gap countdown with done flag on the final gap cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      gap_run <= 1'b0;
      gap_cnt <= 3'd0;
    end else if (gap_start) begin
      gap_run <= 1'b1;
      gap_cnt <= 3'(WRITE_GAP - 1);
    end else if (gap_run) begin
      if (gap_cnt == 3'd0) gap_run <= 1'b0;
      else                 gap_cnt <= gap_cnt - 3'd1;
    end
  end

  assign gap_done = gap_run && (gap_cnt == 3'd0);

  // Sequencer never walks past the table end
  a_step_bound: assert property (@(posedge clk) disable iff (!rst)
    (op != op_idle) |-> (step <= seq_len));

endmodule

//--- src/can_cfg_if.sv
interface can_cfg_if;
  import can_cfg_pkg::*;

  cfg_op_t     op;      // Active command
  logic [4:0]  addr;    // Register being formatted
  logic        fetch;   // Request word for addr
  logic        capture; // Latch host values, once per command
  logic [15:0] word;    // Formatted register word

  // Sequencer side
  modport seq (
    output op,
    output addr,
    output fetch,
    output capture
  );

  // Formatter side
  modport fmt (
    input  op,
    input  addr,
    input  fetch,
    input  capture,
    output word
  );

endinterface

//--- src/can_cfg_pkg.sv
package can_cfg_pkg;

  // Active command latched by the sequencer
  typedef enum logic [2:0] {
    op_idle      = 3'd0,
    op_init      = 3'd1,
    op_send      = 3'd2,
    op_trim      = 3'd3,
    op_bus_reset = 3'd4
  } cfg_op_t;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_fetch = 3'd1,
    st_write = 3'd2,
    st_gap   = 3'd3,
    st_done  = 3'd4
  } seq_state_t;

  // Controller register map
  localparam logic [4:0] ADDR_PRESCALER = 5'h0F; // Baud prescaler
  localparam logic [4:0] ADDR_GENERAL   = 5'h0E; // SJW, TSEG1, TSEG2
  localparam logic [4:0] ADDR_ID_HI     = 5'h05; // Own ID 28-13
  localparam logic [4:0] ADDR_ID_LO     = 5'h04; // Own ID 12-0
  localparam logic [4:0] ADDR_IRQ       = 5'h12; // Interrupt enable
  localparam logic [4:0] ADDR_MASK_HI   = 5'h11; // Acceptance mask high
  localparam logic [4:0] ADDR_MASK_LO   = 5'h10; // Acceptance mask low
  localparam logic [4:0] ADDR_TRA_ID    = 5'h0C; // TX identifier
  localparam logic [4:0] ADDR_TRA_D12   = 5'h0A; // TX data bytes 1-2
  localparam logic [4:0] ADDR_TRA_D34   = 5'h09; // TX data bytes 3-4
  localparam logic [4:0] ADDR_TRA_D56   = 5'h08; // TX data bytes 5-6
  localparam logic [4:0] ADDR_TRA_D78   = 5'h07; // TX data bytes 7-8
  localparam logic [4:0] ADDR_TRA_CTRL  = 5'h0D; // TX control

  // Fixed register words
  localparam logic [15:0] TRA_CONTROL_WORD = 16'h8008; // Start TX with DLC 8
  localparam logic [15:0] IRQ_ENABLE_WORD  = 16'h8070; // Comm enable plus IRQs
  localparam logic [15:0] GEN_DATA_WORD    = 16'h009C; // Default general setting

  localparam int MSG_W = 76; // 11-bit ID plus 64 data bits plus spare

  // Densest toggle pattern for trim runs
  localparam logic [MSG_W-1:0] TRIM_PATTERN = {12'h555, 64'hAAAA_AAAA_AAAA_AAAA};

  // Writes per command
  localparam logic [2:0] INIT_LEN  = 3'd7;
  localparam logic [2:0] SEND_LEN  = 3'd7;
  localparam logic [2:0] TRIM_LEN  = 3'd7;
  localparam logic [2:0] RESET_LEN = 3'd2;

  localparam int WRITE_GAP = 4; // Idle cycles after each write strobe

endpackage
